// File: run_sim.sh
#!/bin/sh
# compile the usb fx3 core and its testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_usb_fx3_core -f usb_fx3_core.f -o tb_usb_fx3_core > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_usb_fx3_core > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
  echo "testbench reported failures, see $SIM_LOG"
  exit 1
fi

echo "no failures found in $SIM_LOG"
exit 0

// File: tb_clk_gen.sv
// ****************************************
// testbench clock and synchronous reset source
// ****************************************

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int CLK_PERIOD = 4,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // reset is released on a falling edge, away from the sampling edge
  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// File: tb_usb_fx3_core.sv
// ****************************************
// testbench of the usb fx3 core, drives the up_ bus and the GPIF side
// and checks the responses with concurrent assertions, run by run_sim.sh
// ****************************************

`timescale 1ns/1ps

`include "usb_fx3_settings.svh"

module tb_usb_fx3_core import usb_fx3_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int FIFO_N          = `USB_FX3_FIFO_NUM;
  localparam int N_TESTS         = 5;
  localparam int WATCHDOG_CYCLES = 200 * N_TESTS + 255 + `USB_FX3_MAX_PAYLOAD;

  logic              up_clk;
  logic              up_rstn;
  logic              up_wreq;
  logic [13:0]       up_waddr;
  logic [31:0]       up_wdata;
  logic              up_wack;
  logic              up_rreq;
  logic [13:0]       up_raddr;
  logic [31:0]       up_rdata;
  logic              up_rack;
  logic [FIFO_N-1:0] fifo_rdy;
  logic              gpif_error;
  logic              rx_valid;
  logic [31:0]       rx_data;
  logic              tx_valid;
  logic [31:0]       tx_data;
  logic              irq;
  logic              zlp;

  int                errors = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                test_mark = 0;
  integer            seed = 32'h30c6;
  int                bad;
  logic [31:0]       vals [7];
  logic [13:0]       regs [7];

  // expected values and enables set by the stimulus tasks
  logic [31:0]       rd_exp = 32'd0;
  logic              tx_clear = 1'b0;
  int                tx_cnt = 0;
  int                tx_hdr = 0;
  int                tx_len_exp = 0;
  pattern_mode_t     tx_mode = PAT_OFF;
  logic              tx_allowed = 1'b0;
  logic              tx_aborting = 1'b0;
  logic              irq_check = 1'b0;
  logic [FIFO_N-1:0] en_model = '0;
  logic [1:0]        irq_cfg_model = 2'd0;
  logic [31:0]       tx_expect;
  logic              irq_exp;
  logic              wreq_on;
  logic              rreq_on;

  tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD)) i_clk_gen (.clk(up_clk), .rstn(up_rstn));

  usb_fx3_core uut (.*);

  function automatic logic [31:0] expected_pattern(input pattern_mode_t mode, input int n);
    logic [31:0] word;
    word = 32'd0;
    if (mode == PAT_RAMP) begin
      word = 32'(n);
    end else if (mode == PAT_ALT) begin
      word = ((n % 2) == 0) ? 32'h5555aaaa : 32'haaaa5555;
    end
    return word;
  endfunction

  function automatic logic [13:0] ofs_addr(input logic [4:0] ofs);
    return {9'd0, ofs};
  endfunction

  assign wreq_on   = up_wreq && (up_waddr[13:8] == 6'd0);
  assign rreq_on   = up_rreq && (up_raddr[13:8] == 6'd0);
  assign tx_expect = (tx_cnt < tx_hdr) ? 32'd0 : expected_pattern(tx_mode, tx_cnt - tx_hdr);
  assign irq_exp   = ((|(en_model & fifo_rdy)) & irq_cfg_model[0]) |
                     (gpif_error & irq_cfg_model[1]);

  // counts tx words since the last clear
  always @(posedge up_clk) begin
    if (tx_clear) begin
      tx_cnt <= 0;
    end else if (tx_valid) begin
      tx_cnt <= tx_cnt + 1;
    end
  end

  // ****************************************
  // checks
  // ****************************************

  a_wack: assert property (@(posedge up_clk) disable iff (!up_rstn) up_wack == $past(wreq_on))
    else report_mismatch("up_wack does not follow the page write request by one cycle");
  a_rack: assert property (@(posedge up_clk) disable iff (!up_rstn) up_rack == $past(rreq_on))
    else report_mismatch("up_rack does not follow the page read request by one cycle");
  a_rdata: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |-> up_rdata == rd_exp) else report_mismatch("read data differs from expected");
  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rack |-> up_rdata == 32'd0) else report_mismatch("read data not zero without ack");
  a_tx_allowed: assert property (@(posedge up_clk) disable iff (!up_rstn)
    tx_valid |-> tx_allowed) else report_mismatch("tx_valid high outside a transfer");
  a_tx_data: assert property (@(posedge up_clk) disable iff (!up_rstn)
    tx_valid |-> tx_data == tx_expect) else report_mismatch("tx word differs from expected");
  a_tx_start: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $rose(tx_valid) |-> tx_cnt == 0) else report_mismatch("tx_valid restarted within a burst");
  a_tx_len: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $fell(tx_valid) && !tx_aborting |-> tx_cnt == tx_len_exp)
    else report_mismatch("tx burst length differs from header plus buffer size");
  a_irq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    irq_check |-> irq == irq_exp) else report_mismatch("irq differs from the enabled sources");
  a_err_stop: assert property (@(posedge up_clk) disable iff (!up_rstn)
    gpif_error |=> !tx_valid && !zlp) else report_mismatch("gpif_error did not stop the transfer");

  task automatic report_mismatch(input string what);
    errors++;
    $display("Mismatch at %0t ns: %s", $time, what);
  endtask

  // ****************************************
  // stimulus tasks, all inputs change on the falling edge
  // ****************************************

  task automatic bus_write(input logic [13:0] addr, input logic [31:0] data);
    @(negedge up_clk);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq  = 1'b0;
  endtask

  task automatic bus_read(input logic [13:0] addr, input logic [31:0] exp);
    @(negedge up_clk);
    up_rreq  = 1'b1;
    up_raddr = addr;
    rd_exp   = exp;
    @(negedge up_clk);
    up_rreq  = 1'b0;
  endtask

  // header words are random, a payload word at bad_idx gets one bit flipped
  task automatic rx_burst(input int n_hdr, input int n_pay, input pattern_mode_t mode,
                          input int bad_idx);
    int gap;
    for (int i = 0; i < n_hdr + n_pay; i++) begin
      gap = int'($unsigned($random(seed)) % 3);
      repeat (gap) begin
        @(negedge up_clk);
        rx_valid = 1'b0;
      end
      @(negedge up_clk);
      rx_valid = 1'b1;
      if (i < n_hdr) begin
        rx_data = $random(seed);
      end else begin
        rx_data = expected_pattern(mode, i - n_hdr) ^
                  (((i - n_hdr) == bad_idx) ? 32'h00010000 : 32'd0);
      end
    end
    @(negedge up_clk);
    rx_valid = 1'b0;
  endtask

  task automatic clear_tx_count();
    @(negedge up_clk);
    tx_clear = 1'b1;
    @(negedge up_clk);
    tx_clear = 1'b0;
  endtask

  task automatic wait_tx_done(input int max_cycles);
    int n;
    n = 0;
    while (!((tx_cnt == tx_len_exp) && !tx_valid) && (n < max_cycles)) begin
      @(negedge up_clk);
      n++;
    end
    if (!((tx_cnt == tx_len_exp) && !tx_valid)) begin
      errors++;
      $display("out transfer did not finish within %0d cycles at %0t ns", max_cycles, $time);
    end
  endtask

  task automatic run_out_transfer(input pattern_mode_t mode);
    tx_mode = mode;
    bus_write(ofs_addr(`USB_FX3_ADDR_TPG_CONFIG), 32'(mode));
    clear_tx_count();
    bus_write(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'h80000001);
    wait_tx_done(100);
    repeat (2) @(negedge up_clk);
    bus_read(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'h00000001);
    bus_read(ofs_addr(`USB_FX3_ADDR_LENGTH_OUT), 32'd23);
  endtask

  task automatic close_test(input string name);
    repeat (4) @(negedge up_clk);
    if (errors == test_mark) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, errors - test_mark);
    end
    test_mark = errors;
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    up_wreq    = 1'b0;
    up_waddr   = 14'd0;
    up_wdata   = 32'd0;
    up_rreq    = 1'b0;
    up_raddr   = 14'd0;
    fifo_rdy   = '0;
    gpif_error = 1'b0;
    rx_valid   = 1'b0;
    rx_data    = 32'd0;
    for (int k = 0; k < 4; k++) begin
      regs[k] = ofs_addr(5'(k));
    end
    regs[4] = ofs_addr(`USB_FX3_ADDR_IRQ_CONFIG);
    regs[5] = ofs_addr(`USB_FX3_ADDR_TPG_CONFIG);
    regs[6] = ofs_addr(`USB_FX3_ADDR_TPM_CONFIG);
    wait (up_rstn === 1'b1);

    for (int a = 0; a < 32; a++) begin
      bus_read(ofs_addr(5'(a)), (a < FIFO_N) ? `USB_FX3_FIFO_CFG_RST : 32'd0);
    end
    for (int k = 0; k < 4; k++) begin
      bus_read(14'h0100 | 14'($random(seed)), 32'd0);
    end
    close_test("reset and map");

    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 7; k++) begin
        vals[k] = $random(seed);
        bus_write(regs[k], vals[k]);
      end
      // a write to another page leaves the registers untouched
      bus_write(14'h0200 | regs[0], ~vals[0]);
      for (int k = 0; k < 7; k++) begin
        bus_read(regs[k], vals[k]);
      end
    end
    close_test("readback");

    // FIFO 1 out, header 3, buffer 20
    tx_hdr      = 3;
    tx_len_exp  = 23;
    tx_allowed  = 1'b1;
    tx_aborting = 1'b0;
    bus_write(ofs_addr(5'd1), 32'hc0030014);
    run_out_transfer(PAT_RAMP);
    run_out_transfer(PAT_ALT);
    tx_allowed = 1'b0;
    close_test("out transfer");

    // FIFO 2 in, header 2, buffer 12, checked against the alternating pattern
    bus_write(ofs_addr(5'd2), 32'h8002000c);
    bus_write(ofs_addr(`USB_FX3_ADDR_TPM_CONFIG), 32'(PAT_ALT));
    bus_write(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'h80000002);
    rx_burst(2, 12, PAT_ALT, -1);
    repeat (3) @(negedge up_clk);
    bus_read(ofs_addr(`USB_FX3_ADDR_LENGTH_IN), 32'd14);
    bus_read(ofs_addr(`USB_FX3_ADDR_TPM_STATUS), 32'd0);
    bus_read(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'h00000002);
    bad = int'($unsigned($random(seed)) % 12);
    bus_write(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'h80000002);
    rx_burst(2, 12, PAT_ALT, bad);
    repeat (3) @(negedge up_clk);
    bus_read(ofs_addr(`USB_FX3_ADDR_LENGTH_IN), 32'd14);
    bus_read(ofs_addr(`USB_FX3_ADDR_TPM_STATUS), 32'd1);
    bus_write(ofs_addr(`USB_FX3_ADDR_TPM_STATUS), 32'd1);
    bus_read(ofs_addr(`USB_FX3_ADDR_TPM_STATUS), 32'd0);
    close_test("in transfer and monitor");

    for (int r = 0; r < 3; r++) begin
      irq_check = 1'b0;
      for (int f = 0; f < FIFO_N; f++) begin
        en_model[f] = 1'($random(seed));
        bus_write(ofs_addr(5'(f)), {en_model[f], 31'h00040008});
      end
      irq_cfg_model = 2'($random(seed));
      bus_write(ofs_addr(`USB_FX3_ADDR_IRQ_CONFIG), 32'(irq_cfg_model));
      irq_check = 1'b1;
      for (int k = 0; k < 6; k++) begin
        @(negedge up_clk);
        fifo_rdy   = FIFO_N'($random(seed));
        gpif_error = (($random(seed) & 7) == 0);
        @(negedge up_clk);
        bus_read(ofs_addr(`USB_FX3_ADDR_FIFO_STATUS), 32'(fifo_rdy));
      end
      gpif_error = 1'b0;
    end
    irq_check = 1'b0;
    fifo_rdy  = '0;
    bus_write(ofs_addr(`USB_FX3_ADDR_XFER_STATUS), 32'd1);
    bus_read(ofs_addr(`USB_FX3_ADDR_XFER_STATUS), 32'd0);

    // long out transfer on FIFO 3 with zlp set, cut short by a controller error
    tx_hdr      = 8;
    tx_len_exp  = 208;
    tx_mode     = PAT_RAMP;
    tx_allowed  = 1'b1;
    tx_aborting = 1'b1;
    bus_write(ofs_addr(5'd3), 32'hc00800c8);
    bus_write(ofs_addr(`USB_FX3_ADDR_TPG_CONFIG), 32'(PAT_RAMP));
    clear_tx_count();
    bus_write(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'hc0000003);
    repeat (20) @(negedge up_clk);
    if (!tx_valid || !zlp) begin
      errors++;
      $display("out transfer was not running before the error pulse at %0t ns", $time);
    end
    gpif_error = 1'b1;
    @(negedge up_clk);
    gpif_error = 1'b0;
    tx_allowed = 1'b0;
    repeat (4) @(negedge up_clk);
    tx_aborting = 1'b0;
    bus_read(ofs_addr(`USB_FX3_ADDR_XFER_CONFIG), 32'h00000003);
    bus_read(ofs_addr(`USB_FX3_ADDR_XFER_STATUS), 32'd1);
    bus_write(ofs_addr(`USB_FX3_ADDR_XFER_STATUS), 32'd1);
    bus_read(ofs_addr(`USB_FX3_ADDR_XFER_STATUS), 32'd0);
    close_test("interrupt and error");

    $display("tests passed %0d failed %0d, failed checks %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

// File: usb_fx3_core.f
+incdir+.
usb_fx3_pkg.sv
usb_fx3_reg.sv
usb_fx3_xfer.sv
usb_fx3_tpg.sv
usb_fx3_tpm.sv
usb_fx3_core.sv
tb_clk_gen.sv
tb_usb_fx3_core.sv

// File: usb_fx3_core.sv
// ****************************************
// top level of the usb fx3 slave core, register block plus transfer datapath
// ****************************************

`timescale 1ns/1ps

`include "usb_fx3_settings.svh"

module usb_fx3_core import usb_fx3_pkg::*; (
  input  logic                         up_clk,
  input  logic                         up_rstn,
  input  logic                         up_wreq,
  input  logic [13:0]                  up_waddr,
  input  logic [31:0]                  up_wdata,
  output logic                         up_wack,
  input  logic                         up_rreq,
  input  logic [13:0]                  up_raddr,
  output logic [31:0]                  up_rdata,
  output logic                         up_rack,
  input  logic [`USB_FX3_FIFO_NUM-1:0] fifo_rdy,
  input  logic                         gpif_error,
  input  logic                         rx_valid,
  input  logic [31:0]                  rx_data,
  output logic                         tx_valid,
  output logic [31:0]                  tx_data,
  output logic                         irq,
  output logic                         zlp
);

  xfer_cmd_t     cmd;
  pattern_mode_t tpg_mode;
  pattern_mode_t tpm_mode;
  logic          eot_out;
  logic          eot_in;
  logic [31:0]   length_out;
  logic [31:0]   length_in;
  logic          pat_start;
  logic          pat_next;
  logic [31:0]   pat_data;
  logic          chk_valid;
  logic [31:0]   chk_data;
  logic          monitor_error;

  usb_fx3_reg i_reg (
    .up_clk        (up_clk),
    .up_rstn       (up_rstn),
    .up_wreq       (up_wreq),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_wack       (up_wack),
    .up_rreq       (up_rreq),
    .up_raddr      (up_raddr),
    .up_rdata      (up_rdata),
    .up_rack       (up_rack),
    .fifo_rdy      (fifo_rdy),
    .gpif_error    (gpif_error),
    .monitor_error (monitor_error),
    .eot_out       (eot_out),
    .eot_in        (eot_in),
    .length_out    (length_out),
    .length_in     (length_in),
    .cmd           (cmd),
    .tpg_mode      (tpg_mode),
    .tpm_mode      (tpm_mode),
    .zlp           (zlp),
    .irq           (irq)
  );

  usb_fx3_xfer i_xfer (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .cmd        (cmd),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .pat_data   (pat_data),
    .tx_valid   (tx_valid),
    .tx_data    (tx_data),
    .pat_start  (pat_start),
    .pat_next   (pat_next),
    .chk_valid  (chk_valid),
    .chk_data   (chk_data),
    .eot_out    (eot_out),
    .eot_in     (eot_in),
    .length_out (length_out),
    .length_in  (length_in)
  );

  usb_fx3_tpg i_tpg (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .tpg_mode  (tpg_mode),
    .pat_start (pat_start),
    .pat_next  (pat_next),
    .pat_data  (pat_data)
  );

  usb_fx3_tpm i_tpm (
    .up_clk        (up_clk),
    .up_rstn       (up_rstn),
    .tpm_mode      (tpm_mode),
    .pat_start     (pat_start),
    .chk_valid     (chk_valid),
    .chk_data      (chk_data),
    .monitor_error (monitor_error)
  );

endmodule

// File: usb_fx3_pkg.sv
// ****************************************
// shared types of the usb fx3 core, imported by the register block and datapath
// ****************************************

package usb_fx3_pkg;

  // one FIFO config word as seen on the register bus
  typedef struct packed {
    logic        enable;
    logic        direction;
    logic [5:0]  reserved;
    logic [7:0]  header_size;
    logic [15:0] buffer_size;
  } fifo_cfg_t;

  // command from the register block to the transfer engine
  typedef struct packed {
    logic       trig;
    logic [4:0] fifo_num;
    logic       direction;
    logic [7:0] header_size;
    logic [8:0] buffer_size;
  } xfer_cmd_t;

  typedef enum logic [1:0] {
    XFER_IDLE    = 2'd0,
    XFER_HEADER  = 2'd1,
    XFER_PAYLOAD = 2'd2,
    XFER_DONE    = 2'd3
  } xfer_state_t;

  typedef enum logic [2:0] {
    PAT_OFF  = 3'd0,
    PAT_RAMP = 3'd1,
    PAT_ALT  = 3'd2
  } pattern_mode_t;

  // payload word index, wide enough for the largest transfer
  typedef logic [8:0] pat_idx_t;

  // word n of a transfer for the given pattern, unknown codes give zero
  function automatic logic [31:0] pattern_word(pattern_mode_t mode, pat_idx_t idx);
    logic [31:0] word;
    case (mode)
      PAT_RAMP: word = 32'(idx);
      PAT_ALT:  word = idx[0] ? 32'haaaa5555 : 32'h5555aaaa;
      default:  word = 32'd0;
    endcase
    return word;
  endfunction

endpackage

// File: usb_fx3_reg.sv
// ****************************************
// processor register map of the usb fx3 core on the up_ bus, with the
// interrupt, sticky error flags and the self-clearing transfer trigger
// ****************************************

`timescale 1ns/1ps

`include "usb_fx3_settings.svh"

module usb_fx3_reg import usb_fx3_pkg::*; (
  input  logic                         up_clk,
  input  logic                         up_rstn,
  input  logic                         up_wreq,
  input  logic [13:0]                  up_waddr,
  input  logic [31:0]                  up_wdata,
  output logic                         up_wack,
  input  logic                         up_rreq,
  input  logic [13:0]                  up_raddr,
  output logic [31:0]                  up_rdata,
  output logic                         up_rack,
  input  logic [`USB_FX3_FIFO_NUM-1:0] fifo_rdy,
  input  logic                         gpif_error,
  input  logic                         monitor_error,
  input  logic                         eot_out,
  input  logic                         eot_in,
  input  logic [31:0]                  length_out,
  input  logic [31:0]                  length_in,
  output xfer_cmd_t                    cmd,
  output pattern_mode_t                tpg_mode,
  output pattern_mode_t                tpm_mode,
  output logic                         zlp,
  output logic                         irq
);

  localparam int FIFO_AW = (`USB_FX3_FIFO_NUM > 1) ? $clog2(`USB_FX3_FIFO_NUM) : 1;

  fifo_cfg_t                    fifo_cfg [`USB_FX3_FIFO_NUM];
  logic [`USB_FX3_FIFO_NUM-1:0] fifo_status;
  logic [`USB_FX3_FIFO_NUM-1:0] fifo_irq;
  logic [31:0]                  irq_config;
  logic [31:0]                  transfer_config;
  logic [31:0]                  tpm_config;
  logic [31:0]                  tpg_config;
  logic                         transfer_status;
  logic                         tpm_status;
  logic                         up_wreq_s;
  logic                         up_rreq_s;
  logic [4:0]                   waddr_ofs;
  logic [4:0]                   raddr_ofs;
  logic [31:0]                  rdata_mux;
  fifo_cfg_t                    sel_cfg;

  // only page zero of the address space belongs to this core
  assign up_wreq_s = (up_waddr[13:8] == `USB_FX3_PAGE) & up_wreq;
  assign up_rreq_s = (up_raddr[13:8] == `USB_FX3_PAGE) & up_rreq;

  // offsets into the FIFO config block, lower addresses wrap and miss
  assign waddr_ofs = up_waddr[4:0] - `USB_FX3_ADDR_FIFO_CFG;
  assign raddr_ofs = up_raddr[4:0] - `USB_FX3_ADDR_FIFO_CFG;

  // ****************************************
  // write side
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack <= 1'b0;
      for (int i = 0; i < `USB_FX3_FIFO_NUM; i++) begin
        fifo_cfg[i] <= `USB_FX3_FIFO_CFG_RST;
      end
      fifo_status     <= '0;
      irq_config      <= 32'd0;
      transfer_config <= 32'd0;
      transfer_status <= 1'b0;
      tpm_config      <= 32'd0;
      tpm_status      <= 1'b0;
      tpg_config      <= 32'd0;
    end else begin
      up_wack     <= up_wreq_s;
      fifo_status <= fifo_rdy;
      if (up_wreq_s && (waddr_ofs < 5'(`USB_FX3_FIFO_NUM))) begin
        fifo_cfg[waddr_ofs[FIFO_AW-1:0]] <= up_wdata;
      end
      if (up_wreq_s && (up_waddr[4:0] == `USB_FX3_ADDR_IRQ_CONFIG)) begin
        irq_config <= up_wdata;
      end
      // end of transfer or a controller error drops trig and zlp
      if (eot_out || eot_in || gpif_error) begin
        transfer_config[31:30] <= 2'b00;
      end else if (up_wreq_s && (up_waddr[4:0] == `USB_FX3_ADDR_XFER_CONFIG)) begin
        transfer_config <= up_wdata;
      end
      // sticky flags, a new event beats a clear in the same cycle
      if (gpif_error) begin
        transfer_status <= 1'b1;
      end else if (up_wreq_s && (up_waddr[4:0] == `USB_FX3_ADDR_XFER_STATUS) && up_wdata[0]) begin
        transfer_status <= 1'b0;
      end
      if (up_wreq_s && (up_waddr[4:0] == `USB_FX3_ADDR_TPM_CONFIG)) begin
        tpm_config <= up_wdata;
      end
      if (monitor_error) begin
        tpm_status <= 1'b1;
      end else if (up_wreq_s && (up_waddr[4:0] == `USB_FX3_ADDR_TPM_STATUS) && up_wdata[0]) begin
        tpm_status <= 1'b0;
      end
      if (up_wreq_s && (up_waddr[4:0] == `USB_FX3_ADDR_TPG_CONFIG)) begin
        tpg_config <= up_wdata;
      end
    end
  end

  // ****************************************
  // read side
  // ****************************************

  always_comb begin
    rdata_mux = 32'd0;
    if (raddr_ofs < 5'(`USB_FX3_FIFO_NUM)) begin
      rdata_mux = fifo_cfg[raddr_ofs[FIFO_AW-1:0]];
    end else begin
      case (up_raddr[4:0])
        `USB_FX3_ADDR_FIFO_STATUS: rdata_mux = 32'(fifo_status);
        `USB_FX3_ADDR_IRQ_CONFIG:  rdata_mux = irq_config;
        `USB_FX3_ADDR_XFER_CONFIG: rdata_mux = transfer_config;
        `USB_FX3_ADDR_XFER_STATUS: rdata_mux = 32'(transfer_status);
        `USB_FX3_ADDR_TPM_CONFIG:  rdata_mux = tpm_config;
        `USB_FX3_ADDR_TPM_STATUS:  rdata_mux = 32'(tpm_status);
        `USB_FX3_ADDR_TPG_CONFIG:  rdata_mux = tpg_config;
        `USB_FX3_ADDR_LENGTH_OUT:  rdata_mux = length_out;
        `USB_FX3_ADDR_LENGTH_IN:   rdata_mux = length_in;
        default:                   rdata_mux = 32'd0;
      endcase
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= 32'd0;
    end else begin
      up_rack  <= up_rreq_s;
      up_rdata <= up_rreq_s ? rdata_mux : 32'd0;
    end
  end

  // ****************************************
  // engine command and interrupt
  // ****************************************

  // the selected FIFO supplies direction and sizes, the payload is capped
  always_comb begin
    sel_cfg = '0;
    if (transfer_config[4:0] < 5'(`USB_FX3_FIFO_NUM)) begin
      sel_cfg = fifo_cfg[transfer_config[FIFO_AW-1:0]];
    end
    cmd.trig        = transfer_config[31];
    cmd.fifo_num    = transfer_config[4:0];
    cmd.direction   = sel_cfg.direction;
    cmd.header_size = sel_cfg.header_size;
    if (sel_cfg.buffer_size > 16'(`USB_FX3_MAX_PAYLOAD)) begin
      cmd.buffer_size = 9'(`USB_FX3_MAX_PAYLOAD);
    end else begin
      cmd.buffer_size = sel_cfg.buffer_size[8:0];
    end
  end

  assign zlp      = transfer_config[30];
  assign tpg_mode = pattern_mode_t'(tpg_config[2:0]);
  assign tpm_mode = pattern_mode_t'(tpm_config[2:0]);

  always_comb begin
    for (int i = 0; i < `USB_FX3_FIFO_NUM; i++) begin
      fifo_irq[i] = fifo_cfg[i].enable & fifo_rdy[i];
    end
  end

  // bit 0 enables the ready interrupt and bit 1 the error interrupt
  assign irq = ((|fifo_irq) & irq_config[0]) | (gpif_error & irq_config[1]);

  a_wack_after_req: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $rose(up_wack) |-> $past(up_wreq));

  // the engine must never see trig still high once it has signalled the end
  a_trig_clear_on_eot: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (eot_out || eot_in) |=> !cmd.trig);

endmodule

// File: usb_fx3_settings.svh
// ****************************************
// build constants for the usb fx3 slave core, included by every module that
// needs the FIFO count, register offsets or reset values
// ****************************************

`ifndef USB_FX3_SETTINGS_SVH
`define USB_FX3_SETTINGS_SVH

`define USB_FX3_FIFO_NUM         4
`define USB_FX3_FIFO_CFG_RST     32'h00100400
`define USB_FX3_MAX_PAYLOAD      511

// register page and word offsets on the up_ bus
`define USB_FX3_PAGE             6'h00
`define USB_FX3_ADDR_FIFO_CFG    5'h00
`define USB_FX3_ADDR_FIFO_STATUS 5'h10
`define USB_FX3_ADDR_IRQ_CONFIG  5'h11
`define USB_FX3_ADDR_XFER_CONFIG 5'h12
`define USB_FX3_ADDR_XFER_STATUS 5'h13
`define USB_FX3_ADDR_TPM_CONFIG  5'h14
`define USB_FX3_ADDR_TPM_STATUS  5'h15
`define USB_FX3_ADDR_TPG_CONFIG  5'h16
`define USB_FX3_ADDR_LENGTH_OUT  5'h18
`define USB_FX3_ADDR_LENGTH_IN   5'h19

`endif

// File: usb_fx3_tpg.sv
// ****************************************
// test pattern generator, feeds one payload word per pat_next strobe
// ****************************************

`timescale 1ns/1ps

module usb_fx3_tpg import usb_fx3_pkg::*; (
  input  logic          up_clk,
  input  logic          up_rstn,
  input  pattern_mode_t tpg_mode,
  input  logic          pat_start,
  input  logic          pat_next,
  output logic [31:0]   pat_data
);

  pat_idx_t idx;

  // index restarts at every transfer and steps once per word taken
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      idx <= '0;
    end else if (pat_start) begin
      idx <= '0;
    end else if (pat_next) begin
      idx <= idx + 1'b1;
    end
  end

  // the word for the current index is ready before the engine samples it
  assign pat_data = pattern_word(tpg_mode, idx);

endmodule

// File: usb_fx3_tpm.sv
// ****************************************
// test pattern monitor, checks each received payload word against the
// expected pattern and flags a mismatch for one cycle
// ****************************************

`timescale 1ns/1ps

module usb_fx3_tpm import usb_fx3_pkg::*; (
  input  logic          up_clk,
  input  logic          up_rstn,
  input  pattern_mode_t tpm_mode,
  input  logic          pat_start,
  input  logic          chk_valid,
  input  logic [31:0]   chk_data,
  output logic          monitor_error
);

  pat_idx_t    idx;
  logic [31:0] expected;
  logic        active;

  assign active   = (tpm_mode == PAT_RAMP) || (tpm_mode == PAT_ALT);
  assign expected = pattern_word(tpm_mode, idx);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      idx           <= '0;
      monitor_error <= 1'b0;
    end else begin
      monitor_error <= chk_valid && active && (chk_data != expected);
      if (pat_start) begin
        idx <= '0;
      end else if (chk_valid) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // an error always comes from a word checked in an active mode
  a_no_error_when_off: assert property (@(posedge up_clk) disable iff (!up_rstn)
    monitor_error |-> $past(chk_valid) && ($past(tpm_mode) != PAT_OFF));

endmodule

// File: usb_fx3_xfer.sv
// ****************************************
// transfer engine that streams header and payload words to or from the
// selected GPIF FIFO and reports the word count at the end
// ****************************************

`timescale 1ns/1ps

`include "usb_fx3_settings.svh"

module usb_fx3_xfer import usb_fx3_pkg::*; (
  input  logic        up_clk,
  input  logic        up_rstn,
  input  xfer_cmd_t   cmd,
  input  logic        rx_valid,
  input  logic [31:0] rx_data,
  input  logic [31:0] pat_data,
  output logic        tx_valid,
  output logic [31:0] tx_data,
  output logic        pat_start,
  output logic        pat_next,
  output logic        chk_valid,
  output logic [31:0] chk_data,
  output logic        eot_out,
  output logic        eot_in,
  output logic [31:0] length_out,
  output logic [31:0] length_in
);

  // holds a full header plus the largest payload
  localparam int CNT_W = $clog2(255 + `USB_FX3_MAX_PAYLOAD + 1);

  xfer_state_t      state;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_nxt;
  logic [CNT_W-1:0] hdr_q;
  logic [CNT_W-1:0] total_q;
  logic [CNT_W-1:0] start_hdr;
  logic [CNT_W-1:0] start_total;
  logic             dir_q;
  logic             active;
  logic             step;

  assign start_hdr   = CNT_W'(cmd.header_size);
  assign start_total = start_hdr + CNT_W'(cmd.buffer_size);

  // out transfers advance every cycle and in transfers advance on each rx strobe
  assign active  = (state == XFER_HEADER) || (state == XFER_PAYLOAD);
  assign step    = active && cmd.trig && (dir_q || rx_valid);
  assign cnt_nxt = cnt + 1'b1;

  assign pat_start = (state == XFER_IDLE) && cmd.trig;
  assign tx_valid  = active && cmd.trig && dir_q;
  assign tx_data   = (tx_valid && (state == XFER_PAYLOAD)) ? pat_data : 32'd0;
  assign pat_next  = tx_valid && (state == XFER_PAYLOAD);
  assign chk_valid = step && !dir_q && (state == XFER_PAYLOAD);
  assign chk_data  = rx_data;
  assign eot_out   = (state == XFER_DONE) && dir_q;
  assign eot_in    = (state == XFER_DONE) && !dir_q;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state      <= XFER_IDLE;
      cnt        <= '0;
      hdr_q      <= '0;
      total_q    <= '0;
      dir_q      <= 1'b0;
      length_out <= 32'd0;
      length_in  <= 32'd0;
    end else begin
      case (state)
        XFER_IDLE: begin
          if (cmd.trig) begin
            cnt     <= '0;
            hdr_q   <= start_hdr;
            total_q <= start_total;
            dir_q   <= cmd.direction;
            if (start_total == '0) begin
              state <= XFER_DONE;
            end else if (start_hdr == '0) begin
              state <= XFER_PAYLOAD;
            end else begin
              state <= XFER_HEADER;
            end
          end
        end
        XFER_HEADER, XFER_PAYLOAD: begin
          // a dropped trig aborts without reporting a length
          if (!cmd.trig) begin
            state <= XFER_IDLE;
          end else if (step) begin
            cnt <= cnt_nxt;
            if (cnt_nxt == total_q) begin
              state <= XFER_DONE;
            end else if (cnt_nxt == hdr_q) begin
              state <= XFER_PAYLOAD;
            end
          end
        end
        default: begin
          if (dir_q) begin
            length_out <= 32'(cnt);
          end else begin
            length_in <= 32'(cnt);
          end
          state <= XFER_IDLE;
        end
      endcase
    end
  end

  // the out window closes once the word count reaches header plus payload
  a_tx_in_window: assert property (@(posedge up_clk) disable iff (!up_rstn)
    tx_valid |-> active && (cnt < total_q));

endmodule
